//--- verif/cpu_trace.txt
// All values hex. Program: word count, then instruction words from address 0
// Writebacks: count, then group register value; last two: final pc, instruction count
17
08400006 0881fffd 20c22000 21022001  // 0-3 loadi 6, loadi -3, add, sub
21422002 21822003 21c22004 22041005  // 4-7 and, or, xor, sll
22441006 22822007 22c41007 0b000100  // 8-11 srl, sltu, sltu, loadi 0x100
1808c000 13580000 08000055 23801000  // 12-15 store, load, loadi r0, add r0
0bc00013 2800f000 0c000111 0c400016  // 16-19 loadi 19, jumpz taken, skipped, loadi 22
28031000 0c80beef 30000000           // 20-22 jumpz not taken, loadi, halt
// Groups: 1 load immediate, 2 ALU, 3 store/load, 4 jumpz, 5 register 0
11
1 01 00000006
1 02 fffffffd
2 03 00000003
2 04 00000009
2 05 00000004
2 06 ffffffff
2 07 fffffffb
2 08 ffffff40
2 09 03ffffff
2 0a 00000001
2 0b 00000000
3 0c 00000100
3 0d 00000009
5 0e 00000006
4 0f 00000013
4 11 00000016
4 12 0000beef
17
16

//--- project.f
hdl/cpu_pkg.sv
hdl/mem_bus_if.sv
hdl/main_memory.sv
hdl/mem_arbiter.sv
hdl/fetch_unit.sv
hdl/load_store_unit.sv
hdl/stage_control.sv
hdl/register_file.sv
hdl/alu.sv
hdl/cpu_top.sv
verif/cpu_tb.sv

//--- Makefile
SRCS := $(shell cat project.f)

run: obj_dir/Vcpu_tb
	@out="$$(./obj_dir/Vcpu_tb)"; echo "$$out"; echo "$$out" | grep -q 'All tests passed!'

obj_dir/Vcpu_tb: project.f $(SRCS)
	verilator --binary --assert --timescale 1ns/10ps --top-module cpu_tb -f project.f

clean:
	rm -rf obj_dir

.PHONY: run clean

//--- verif/cpu_tb.sv
`timescale 1ns/10ps

module cpu_tb;

   logic        clk = 1'b0;
   logic        rst_n;
   logic        run;
   logic        prog_we;
   logic [10:0] prog_addr;
   logic [31:0] prog_wdata;
   logic [31:0] pc;
   logic        halted;
   logic        wb_valid;
   logic [4:0]  wb_reg;
   logic [31:0] wb_data;

   logic [31:0] trace [256];
   int          prog_len;
   int          wb_count;
   int          wb_base;
   int          instr_count;
   int          timeout_ns;
   logic [31:0] final_pc;
   bit          trace_ready = 1'b0;

   // Counts kept by the writeback monitor
   int          seen = 0;
   int          late_wb = 0;
   int          run_cycles = 0;
   int          wb_pass = 0;
   int          wb_fail = 0;

   int          pass_count = 0;
   int          fail_count = 0;

   cpu_top cpu_top_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .run        (run),
      .prog_we    (prog_we),
      .prog_addr  (prog_addr),
      .prog_wdata (prog_wdata),
      .pc         (pc),
      .halted     (halted),
      .wb_valid   (wb_valid),
      .wb_reg     (wb_reg),
      .wb_data    (wb_data)
   );

   always #4 clk = ~clk;

   function automatic logic [31:0] trace_word(int idx);
      return trace[idx[7:0]];
   endfunction

   function automatic string group_name(logic [31:0] id);
      case (id)
         32'd1:   return "load_immediate";
         32'd2:   return "alu_op";
         32'd3:   return "store_load";
         32'd4:   return "jumpz";
         32'd5:   return "reg_zero";
         default: return "writeback";
      endcase
   endfunction

   function automatic bit compare_value(string name, logic [31:0] expected,
                                        logic [31:0] actual);
      bit ok;
      ok = (actual === expected);
      assert (ok) begin
         $display("Pass %s", name);
      end else begin
         $display("Fail %s expected %h actual %h", name, expected, actual);
      end
      return ok;
   endfunction

   task automatic count_result(bit ok);
      if (ok) begin
         pass_count++;
      end else begin
         fail_count++;
      end
   endtask

   // Next expected entry is group, register, value
   task automatic match_writeback();
      int          idx;
      string       name;
      logic [31:0] exp_word;
      logic [4:0]  exp_reg;
      logic [31:0] exp_data;
      idx = wb_base + 3 * seen;
      assert (seen < wb_count) else begin
         wb_fail++;
         $display("Writeback to r%0d with %h came after the last expected one",
                  wb_reg, wb_data);
      end
      if (seen < wb_count) begin
         name = $sformatf("%s_%0d", group_name(trace_word(idx)), seen);
         exp_word = trace_word(idx + 1);
         exp_reg = exp_word[4:0];
         exp_data = trace_word(idx + 2);
         assert (wb_reg === exp_reg && wb_data === exp_data) begin
            wb_pass++;
            $display("Pass %s r%0d = %h", name, wb_reg, wb_data);
         end else begin
            wb_fail++;
            $display("Fail %s expected r%0d = %h actual r%0d = %h",
                     name, exp_reg, exp_data, wb_reg, wb_data);
         end
         seen++;
      end
   endtask

   // Outputs settle well before the falling edge
   always @(negedge clk) begin
      if (rst_n && run && !halted) begin
         run_cycles++;
      end
      if (wb_valid === 1'b1) begin
         if (halted) begin
            late_wb++;
         end else begin
            match_writeback();
         end
      end
   end

   task automatic load_and_run();
      repeat (16) @(posedge clk);
      #1 rst_n = 1'b1;
      for (int i = 0; i < prog_len; i++) begin
         @(posedge clk);
         #1;
         prog_we = 1'b1;
         prog_addr = i[10:0];
         prog_wdata = trace_word(1 + i);
      end
      @(posedge clk);
      #1;
      prog_we = 1'b0;
      run = 1'b1;
      wait (halted === 1'b1);
      repeat (50) @(negedge clk);
      #1;
      count_result(compare_value("halt_flag", 32'd1, {31'd0, halted}));
      count_result(compare_value("final_pc", final_pc, pc));
      count_result(compare_value("run_cycles", 5 * instr_count, run_cycles));
      count_result(compare_value("writeback_count", wb_count, seen));
      count_result(compare_value("quiet_after_halt", 32'd0, late_wb));
      $display("%0d tests run, %0d passed, %0d failed",
               pass_count + fail_count + wb_pass + wb_fail,
               pass_count + wb_pass, fail_count + wb_fail);
      if (fail_count + wb_fail == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   endtask

   initial begin
      rst_n = 1'b0;
      run = 1'b0;
      prog_we = 1'b0;
      prog_addr = '0;
      prog_wdata = '0;
      $readmemh("verif/cpu_trace.txt", trace);
      if ($isunknown(trace_word(0))) begin
         $display("The trace file verif/cpu_trace.txt could not be read");
         $display("Test failures found");
         $finish;
      end else begin
         prog_len = trace_word(0);
         wb_count = trace_word(prog_len + 1);
         wb_base = prog_len + 2;
         final_pc = trace_word(wb_base + 3 * wb_count);
         instr_count = trace_word(wb_base + 3 * wb_count + 1);
         // Five cycles per instruction with a margin of four, plus reset, load and quiet time
         timeout_ns = instr_count * 5 * 8 * 4 + (16 + prog_len + 2 + 50) * 8;
         trace_ready = 1'b1;
         load_and_run();
      end
   end

   initial begin
      wait (trace_ready);
      #(timeout_ns);
      $display("Timeout after %0d ns, the program did not halt and settle", timeout_ns);
      $display("Test failures found");
      $finish;
   end

endmodule

//--- hdl/cpu_top.sv
`timescale 1ns/10ps

module cpu_top (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               run,
   input  logic               prog_we,
   input  cpu_pkg::mem_addr_t prog_addr,
   input  cpu_pkg::word_t     prog_wdata,
   output cpu_pkg::word_t     pc,
   output logic               halted,
   output logic               wb_valid,
   output cpu_pkg::reg_addr_t wb_reg,
   output cpu_pkg::word_t     wb_data
);

   cpu_pkg::stage_t    stage;
   cpu_pkg::opcode_t   opcode;
   cpu_pkg::reg_addr_t rd_addr_a;
   cpu_pkg::reg_addr_t rd_addr_b;
   cpu_pkg::word_t     rd_data_a;
   cpu_pkg::word_t     rd_data_b;
   cpu_pkg::word_t     operand_a;
   cpu_pkg::word_t     operand_b;
   cpu_pkg::alu_op_t   alu_op;
   cpu_pkg::word_t     alu_result;
   cpu_pkg::word_t     load_data;
   logic               jump_taken;

   mem_bus_if fetch_bus ();
   mem_bus_if lsu_bus ();
   mem_bus_if ram_bus ();

   main_memory main_memory_i (
      .clk (clk),
      .bus (ram_bus.memory)
   );

   mem_arbiter mem_arbiter_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .prog_we    (prog_we),
      .prog_addr  (prog_addr),
      .prog_wdata (prog_wdata),
      .fetch_bus  (fetch_bus.arbiter),
      .lsu_bus    (lsu_bus.arbiter),
      .ram_bus    (ram_bus.requester)
   );

   fetch_unit fetch_unit_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .stage       (stage),
      .run         (run),
      .halted      (halted),
      .jump_taken  (jump_taken),
      .jump_target (operand_b),
      .bus         (fetch_bus.requester),
      .pc          (pc)
   );

   // Store data comes from ra, address from the b operand
   load_store_unit load_store_unit_i (
      .stage       (stage),
      .opcode      (opcode),
      .addr_value  (operand_b),
      .store_value (operand_a),
      .bus         (lsu_bus.requester),
      .load_data   (load_data)
   );

   stage_control stage_control_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .run        (run),
      .fetch_gnt  (fetch_bus.gnt),
      .instr_word (fetch_bus.rdata),
      .rd_data_a  (rd_data_a),
      .rd_data_b  (rd_data_b),
      .alu_result (alu_result),
      .load_data  (load_data),
      .stage      (stage),
      .opcode     (opcode),
      .rd_addr_a  (rd_addr_a),
      .rd_addr_b  (rd_addr_b),
      .operand_a  (operand_a),
      .operand_b  (operand_b),
      .alu_op     (alu_op),
      .wr_en      (wb_valid),
      .wr_addr    (wb_reg),
      .wr_data    (wb_data),
      .jump_taken (jump_taken),
      .halted     (halted)
   );

   register_file register_file_i (
      .clk       (clk),
      .rd_addr_a (rd_addr_a),
      .rd_addr_b (rd_addr_b),
      .rd_data_a (rd_data_a),
      .rd_data_b (rd_data_b),
      .wr_en     (wb_valid),
      .wr_addr   (wb_reg),
      .wr_data   (wb_data)
   );

   alu alu_i (
      .a      (operand_a),
      .b      (operand_b),
      .op     (alu_op),
      .result (alu_result)
   );

endmodule

//--- hdl/alu.sv
`timescale 1ns/10ps

module alu (
   input  cpu_pkg::word_t   a,
   input  cpu_pkg::word_t   b,
   input  cpu_pkg::alu_op_t op,
   output cpu_pkg::word_t   result
);

   always_comb begin
      case (op)
         cpu_pkg::alu_add:  result = a + b;
         cpu_pkg::alu_sub:  result = a - b;
         cpu_pkg::alu_and:  result = a & b;
         cpu_pkg::alu_or:   result = a | b;
         cpu_pkg::alu_xor:  result = a ^ b;
         cpu_pkg::alu_sll:  result = a << b[4:0];
         cpu_pkg::alu_srl:  result = a >> b[4:0];
         default:           result = {31'd0, (a < b)};
      endcase
   end

endmodule

//--- hdl/register_file.sv
`timescale 1ns/10ps

module register_file (
   input  logic               clk,
   input  cpu_pkg::reg_addr_t rd_addr_a,
   input  cpu_pkg::reg_addr_t rd_addr_b,
   output cpu_pkg::word_t     rd_data_a,
   output cpu_pkg::word_t     rd_data_b,
   input  logic               wr_en,
   input  cpu_pkg::reg_addr_t wr_addr,
   input  cpu_pkg::word_t     wr_data
);

   cpu_pkg::word_t regs [cpu_pkg::reg_count];

   always_ff @(posedge clk) begin
      if (wr_en) begin
         regs[wr_addr] <= wr_data;
      end
   end

   // r0 is hardwired to zero
   assign rd_data_a = (rd_addr_a == '0) ? '0 : regs[rd_addr_a];
   assign rd_data_b = (rd_addr_b == '0) ? '0 : regs[rd_addr_b];

endmodule

//--- hdl/stage_control.sv
`timescale 1ns/10ps

module stage_control (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                run,
   input  logic                fetch_gnt,
   input  cpu_pkg::word_t      instr_word,
   input  cpu_pkg::word_t      rd_data_a,
   input  cpu_pkg::word_t      rd_data_b,
   input  cpu_pkg::word_t      alu_result,
   input  cpu_pkg::word_t      load_data,
   output cpu_pkg::stage_t     stage,
   output cpu_pkg::opcode_t    opcode,
   output cpu_pkg::reg_addr_t  rd_addr_a,
   output cpu_pkg::reg_addr_t  rd_addr_b,
   output cpu_pkg::word_t      operand_a,
   output cpu_pkg::word_t      operand_b,
   output cpu_pkg::alu_op_t    alu_op,
   output logic                wr_en,
   output cpu_pkg::reg_addr_t  wr_addr,
   output cpu_pkg::word_t      wr_data,
   output logic                jump_taken,
   output logic                halted
);

   cpu_pkg::word_t     instr_q;
   cpu_pkg::word_t     imm;
   cpu_pkg::reg_addr_t ra;
   logic               advance;
   logic               in_wb;
   logic               writes_reg;

   assign advance = run & ~halted;
   assign in_wb   = advance && (stage == cpu_pkg::st_writeback);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         stage <= cpu_pkg::st_fetch;
      end else if (advance) begin
         case (stage)
            cpu_pkg::st_fetch:     if (fetch_gnt) stage <= cpu_pkg::st_issue;
            cpu_pkg::st_issue:     stage <= cpu_pkg::st_operand;
            cpu_pkg::st_operand:   stage <= cpu_pkg::st_execute;
            cpu_pkg::st_execute:   stage <= cpu_pkg::st_writeback;
            default:               stage <= cpu_pkg::st_fetch;
         endcase
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         halted <= 1'b0;
      end else if (in_wb && opcode == cpu_pkg::op_halt) begin
         halted <= 1'b1;
      end
   end

   // Issue register and operand registers
   always_ff @(posedge clk) begin
      if (advance && stage == cpu_pkg::st_issue) begin
         instr_q <= instr_word;
      end
      if (advance && stage == cpu_pkg::st_operand) begin
         operand_a <= rd_data_a;
         operand_b <= rd_data_b;
      end
   end

   assign opcode  = instr_q[31:27];
   assign wr_addr = instr_q[26:22];
   assign ra      = instr_q[21:17];
   assign alu_op  = instr_q[2:0];
   assign imm     = {{15{instr_q[16]}}, instr_q[16:0]};

   // Loads take their address from ra, so route it to the b port
   assign rd_addr_a = ra;
   assign rd_addr_b = (opcode == cpu_pkg::op_load) ? ra : instr_q[16:12];

   assign writes_reg = (opcode == cpu_pkg::op_loadi) || (opcode == cpu_pkg::op_load) ||
                       (opcode == cpu_pkg::op_alu);

   // Register 0 writes are dropped here
   assign wr_en = in_wb && writes_reg && (wr_addr != '0);

   always_comb begin
      case (opcode)
         cpu_pkg::op_loadi: wr_data = imm;
         cpu_pkg::op_load:  wr_data = load_data;
         default:           wr_data = alu_result;
      endcase
   end

   assign jump_taken = in_wb && (opcode == cpu_pkg::op_jumpz) && (operand_a == '0);

endmodule

//--- hdl/load_store_unit.sv
`timescale 1ns/10ps

module load_store_unit (
   input  cpu_pkg::stage_t  stage,
   input  cpu_pkg::opcode_t opcode,
   input  cpu_pkg::word_t   addr_value,
   input  cpu_pkg::word_t   store_value,
   mem_bus_if.requester     bus,
   output cpu_pkg::word_t   load_data
);

   logic is_load;
   logic is_store;

   assign is_load  = (opcode == cpu_pkg::op_load);
   assign is_store = (opcode == cpu_pkg::op_store);

   // Memory access only in the execute stage
   assign bus.req   = (stage == cpu_pkg::st_execute) && (is_load || is_store);
   assign bus.we    = is_store;
   assign bus.addr  = addr_value[10:0];
   assign bus.wdata = store_value;

   // Read data lands during writeback
   assign load_data = bus.rdata;

endmodule

//--- hdl/fetch_unit.sv
`timescale 1ns/10ps

module fetch_unit (
   input  logic            clk,
   input  logic            rst_n,
   input  cpu_pkg::stage_t stage,
   input  logic            run,
   input  logic            halted,
   input  logic            jump_taken,
   input  cpu_pkg::word_t  jump_target,
   mem_bus_if.requester    bus,
   output cpu_pkg::word_t  pc
);

   logic active;

   assign active = run & ~halted;

   // Instruction read, never a write
   assign bus.req   = active && (stage == cpu_pkg::st_fetch);
   assign bus.we    = 1'b0;
   assign bus.addr  = pc[10:0];
   assign bus.wdata = '0;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc <= '0;
      end else if (active && stage == cpu_pkg::st_writeback) begin
         if (jump_taken) begin
            pc <= jump_target;
         end else begin
            pc <= pc + 32'd1;
         end
      end
   end

endmodule

//--- hdl/mem_arbiter.sv
`timescale 1ns/10ps

module mem_arbiter (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               prog_we,
   input  cpu_pkg::mem_addr_t prog_addr,
   input  cpu_pkg::word_t     prog_wdata,
   mem_bus_if.arbiter         fetch_bus,
   mem_bus_if.arbiter         lsu_bus,
   mem_bus_if.requester       ram_bus
);

   logic fetch_rd_q;
   logic lsu_rd_q;

   // Loader first, then load/store, then fetch
   always_comb begin
      fetch_bus.gnt = 1'b0;
      lsu_bus.gnt   = 1'b0;
      ram_bus.req   = 1'b0;
      ram_bus.we    = 1'b0;
      ram_bus.addr  = '0;
      ram_bus.wdata = '0;
      if (prog_we) begin
         ram_bus.req   = 1'b1;
         ram_bus.we    = 1'b1;
         ram_bus.addr  = prog_addr;
         ram_bus.wdata = prog_wdata;
      end else if (lsu_bus.req) begin
         lsu_bus.gnt   = 1'b1;
         ram_bus.req   = 1'b1;
         ram_bus.we    = lsu_bus.we;
         ram_bus.addr  = lsu_bus.addr;
         ram_bus.wdata = lsu_bus.wdata;
      end else if (fetch_bus.req) begin
         fetch_bus.gnt = 1'b1;
         ram_bus.req   = 1'b1;
         ram_bus.addr  = fetch_bus.addr;
      end
   end

   // Owner of the read in flight
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         fetch_rd_q <= 1'b0;
         lsu_rd_q   <= 1'b0;
      end else begin
         fetch_rd_q <= fetch_bus.gnt & ~fetch_bus.we;
         lsu_rd_q   <= lsu_bus.gnt & ~lsu_bus.we;
      end
   end

   assign fetch_bus.rdata = fetch_rd_q ? ram_bus.rdata : '0;
   assign lsu_bus.rdata   = lsu_rd_q ? ram_bus.rdata : '0;

endmodule

//--- hdl/main_memory.sv
`timescale 1ns/10ps

module main_memory (
   input logic       clk,
   mem_bus_if.memory bus
);

   cpu_pkg::word_t mem [cpu_pkg::mem_depth];

   // Read data appears one cycle after the request
   always_ff @(posedge clk) begin
      if (bus.req) begin
         if (bus.we) begin
            mem[bus.addr] <= bus.wdata;
         end else begin
            bus.rdata <= mem[bus.addr];
         end
      end
   end

endmodule

//--- hdl/mem_bus_if.sv
`timescale 1ns/10ps

interface mem_bus_if;

   logic              req;
   logic              we;
   cpu_pkg::mem_addr_t addr;
   cpu_pkg::word_t    wdata;
   logic              gnt;
   cpu_pkg::word_t    rdata;

   modport requester (output req, output we, output addr, output wdata,
                      input gnt, input rdata);

   modport arbiter (input req, input we, input addr, input wdata,
                    output gnt, output rdata);

   modport memory (input req, input we, input addr, input wdata,
                   output rdata);

endinterface

//--- hdl/cpu_pkg.sv
package cpu_pkg;

   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_addr_t;
   typedef logic [10:0] mem_addr_t;
   typedef logic [2:0]  alu_op_t;
   typedef logic [4:0]  opcode_t;

   typedef enum logic [2:0] {
      st_fetch,
      st_issue,
      st_operand,
      st_execute,
      st_writeback
   } stage_t;

   localparam int mem_depth = 2048;
   localparam int reg_count = 32;

   // Opcode 0 and unlisted codes are no-operations
   localparam opcode_t op_loadi = 5'd1;
   localparam opcode_t op_load  = 5'd2;
   localparam opcode_t op_store = 5'd3;
   localparam opcode_t op_alu   = 5'd4;
   localparam opcode_t op_jumpz = 5'd5;
   localparam opcode_t op_halt  = 5'd6;

   localparam alu_op_t alu_add  = 3'd0;
   localparam alu_op_t alu_sub  = 3'd1;
   localparam alu_op_t alu_and  = 3'd2;
   localparam alu_op_t alu_or   = 3'd3;
   localparam alu_op_t alu_xor  = 3'd4;
   localparam alu_op_t alu_sll  = 3'd5;
   localparam alu_op_t alu_srl  = 3'd6;
   localparam alu_op_t alu_sltu = 3'd7;

endpackage
